// File: Makefile
TOP = tb_uart_rx_hub

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^STATUS: PASS$$" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module uart_rx_hub \
		rtl/uart_pkg.sv rtl/rx_byte_if.sv rtl/baud_tick_gen.sv \
		rtl/uart_rx_channel.sv rtl/rx_apb_regs.sv rtl/uart_rx_hub.sv

clean:
	rm -rf obj_dir sim.log

// File: flist.f
rtl/uart_pkg.sv
rtl/rx_byte_if.sv
rtl/baud_tick_gen.sv
rtl/uart_rx_channel.sv
rtl/rx_apb_regs.sv
rtl/uart_rx_hub.sv
sim/rx_checker.sv
sim/tb_uart_rx_hub.sv

// File: rtl/baud_tick_gen.sv
`timescale 1ns/1ps

module baud_tick_gen (
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  logic [uart_pkg::DIV_W-1:0] i_divisor,
    output logic                       o_tick
);
    import uart_pkg::*;

    logic [DIV_W-1:0] cnt;

    // Reload only at zero so a new divisor waits for the current period
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            cnt    <= DIV_RESET;
            o_tick <= 1'b0;
        end else begin
            if (cnt == '0) begin
                cnt    <= i_divisor;
                o_tick <= 1'b1;
            end else begin
                cnt    <= cnt - 1'b1;
                o_tick <= 1'b0;
            end
        end
    end

    // Back-to-back ticks need a zero divisor at the earlier reload
    a_tick_spacing: assert property (
        @(posedge i_clk) disable iff (i_reset)
        (o_tick && $past(o_tick)) |-> ($past(i_divisor, 2) == '0)
    );

endmodule

// File: rtl/rx_apb_regs.sv
`timescale 1ns/1ps

module rx_apb_regs (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_psel,
    input  logic                        i_penable,
    input  logic                        i_pwrite,
    input  logic [uart_pkg::APB_AW-1:0] i_paddr,
    input  logic [uart_pkg::APB_DW-1:0] i_pwdata,
    output logic [uart_pkg::APB_DW-1:0] o_prdata,
    output logic [uart_pkg::DIV_W-1:0]  o_divisor,
    rx_byte_if.snk                      i_bytes [uart_pkg::NUM_CH]
);
    import uart_pkg::*;

    logic [DATA_BITS-1:0] data_q  [NUM_CH];
    logic [DATA_BITS-1:0] in_data [NUM_CH];
    logic [NUM_CH-1:0]    full_q;
    logic [NUM_CH-1:0]    ovr_q;
    logic [NUM_CH-1:0]    ferr_q;
    logic [NUM_CH-1:0]    in_valid;
    logic [NUM_CH-1:0]    in_ferr;
    logic [NUM_CH-1:0]    in_ovr;
    logic [NUM_CH-1:0]    load;
    logic [NUM_CH-1:0]    data_rd;
    logic [NUM_CH-1:0]    clr_ovr;
    logic [NUM_CH-1:0]    clr_ferr;
    logic                 wr_en;
    logic                 rd_en;
    logic                 clr_wr;
    logic [APB_DW-1:0]    status;

    assign wr_en  = i_psel && i_penable && i_pwrite;   // Access phase only
    assign rd_en  = i_psel && i_penable && !i_pwrite;
    assign clr_wr = wr_en && (i_paddr == REG_CLEAR);

    assign clr_ovr  = clr_wr ? i_pwdata[ST_OVR_LSB +: NUM_CH] : '0;
    assign clr_ferr = clr_wr ? i_pwdata[ST_FERR_LSB +: NUM_CH] : '0;

    for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_ch
        assign in_valid[ch]      = i_bytes[ch].valid;
        assign in_data[ch]       = i_bytes[ch].data;
        assign in_ferr[ch]       = i_bytes[ch].frame_err;
        assign in_ovr[ch]        = i_bytes[ch].overrun;
        assign i_bytes[ch].ready = !full_q[ch];
        assign load[ch]          = in_valid[ch] && !full_q[ch];
        assign data_rd[ch]       = rd_en && (i_paddr == DATA_ADDR[ch]);
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_divisor <= DIV_RESET;
        end else if (wr_en && (i_paddr == REG_DIVISOR)) begin
            o_divisor <= i_pwdata[DIV_W-1:0];
        end
    end

    // New events win over a clear in the same cycle
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            full_q <= '0;
            ovr_q  <= '0;
            ferr_q <= '0;
        end else begin
            full_q <= (full_q & ~data_rd) | load;
            ovr_q  <= (ovr_q & ~clr_ovr) | in_ovr;
            ferr_q <= (ferr_q & ~clr_ferr) | (load & in_ferr);
        end
    end

    always_ff @(posedge i_clk) begin
        for (int ch = 0; ch < NUM_CH; ch++) begin
            if (load[ch]) begin
                data_q[ch] <= in_data[ch];
            end
        end
    end

    assign status = APB_DW'({ferr_q, ovr_q, full_q});

    always_comb begin
        o_prdata = '0;
        if (i_psel) begin
            case (i_paddr)
                REG_DIVISOR: o_prdata = APB_DW'(o_divisor);
                REG_STATUS:  o_prdata = status;
                default: begin
                    for (int ch = 0; ch < NUM_CH; ch++) begin
                        if ((i_paddr == DATA_ADDR[ch]) && full_q[ch]) begin
                            o_prdata = APB_DW'(data_q[ch]);  // Empty register reads 0
                        end
                    end
                end
            endcase
        end
    end

    a_penable_psel: assert property (
        @(posedge i_clk) disable iff (i_reset)
        i_penable |-> i_psel
    );

endmodule

// File: rtl/rx_byte_if.sv
`timescale 1ns/1ps

interface rx_byte_if;
    import uart_pkg::*;

    logic                 valid;        // Buffered byte waiting
    logic [DATA_BITS-1:0] data;
    logic                 frame_err;    // Stop bit was low
    logic                 overrun;      // One-cycle pulse, byte dropped
    logic                 ready;        // Data register empty

    modport src (
        output valid,
        output data,
        output frame_err,
        output overrun,
        input  ready
    );

    modport snk (
        input  valid,
        input  data,
        input  frame_err,
        input  overrun,
        output ready
    );

endinterface

// File: rtl/uart_pkg.sv
package uart_pkg;

    // Hub sizing
    localparam int NUM_CH    = 4;           // Receive channels
    localparam int DATA_BITS = 8;           // Data bits per frame
    localparam int APB_AW    = 8;           // APB address width
    localparam int APB_DW    = 32;          // APB data width

    // Oversampling
    localparam int OVERSAMPLE = 16;         // Ticks per bit
    localparam int MID_START  = OVERSAMPLE / 2 - 1;  // Tick count at mid start bit
    localparam int TICK_W     = $clog2(OVERSAMPLE);
    localparam int BIT_W      = $clog2(DATA_BITS);

    // Baud divisor, tick period is divisor + 1 clocks
    localparam int              DIV_W     = 16;
    localparam logic [DIV_W-1:0] DIV_RESET = 16'd26;  // 115200 baud at 50 MHz

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    typedef enum logic [APB_AW-1:0] {
        REG_DIVISOR = 8'h00,
        REG_STATUS  = 8'h04,
        REG_CLEAR   = 8'h08,                // Write 1 to clear stickies
        REG_DATA0   = 8'h10,
        REG_DATA1   = 8'h14,
        REG_DATA2   = 8'h18,
        REG_DATA3   = 8'h1C
    } reg_addr_e;

    // Data register address per channel
    localparam reg_addr_e DATA_ADDR [NUM_CH] = '{
        REG_DATA0,
        REG_DATA1,
        REG_DATA2,
        REG_DATA3
    };

    // Status layout, one field of NUM_CH bits each
    localparam int ST_FULL_LSB = 0;
    localparam int ST_OVR_LSB  = NUM_CH;
    localparam int ST_FERR_LSB = 2 * NUM_CH;

endpackage

// File: rtl/uart_rx_channel.sv
`timescale 1ns/1ps

module uart_rx_channel (
    input  logic   i_clk,
    input  logic   i_reset,
    input  logic   i_tick,
    input  logic   i_rx,
    rx_byte_if.src o_byte
);
    import uart_pkg::*;

    rx_state_e            state;
    logic [2:0]           rx_sync;      // Synchronizer plus edge history
    logic                 rx_s;
    logic                 start_edge;
    logic [TICK_W-1:0]    tick_cnt;
    logic [BIT_W-1:0]     bit_cnt;
    logic [DATA_BITS-1:0] shift_q;
    logic                 bit_end;
    logic                 frame_done;
    logic                 buf_load;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            rx_sync <= 3'b111;          // Idle line is high
        end else begin
            rx_sync <= {rx_sync[1:0], i_rx};
        end
    end

    assign rx_s       = rx_sync[1];
    assign start_edge = rx_sync[2] && !rx_sync[1];
    assign bit_end    = i_tick && (tick_cnt == TICK_W'(OVERSAMPLE - 1));
    assign frame_done = (state == RX_STOP) && bit_end;  // Mid stop bit
    assign buf_load   = frame_done && (!o_byte.valid || o_byte.ready);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state    <= RX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            case (state)
                RX_IDLE: begin
                    tick_cnt <= '0;
                    if (start_edge) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (i_tick) begin
                        if (tick_cnt == TICK_W'(MID_START)) begin
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                            state    <= rx_s ? RX_IDLE : RX_DATA;  // High again means glitch
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        tick_cnt <= '0;
                        if (bit_cnt == BIT_W'(DATA_BITS - 1)) begin
                            state <= RX_STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        state <= RX_IDLE;
                    end else if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB first
    always_ff @(posedge i_clk) begin
        if ((state == RX_DATA) && bit_end) begin
            shift_q <= {rx_s, shift_q[DATA_BITS-1:1]};
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_byte.valid   <= 1'b0;
            o_byte.overrun <= 1'b0;
        end else begin
            o_byte.overrun <= frame_done && !buf_load;  // Buffer still full
            if (buf_load) begin
                o_byte.valid <= 1'b1;
            end else if (o_byte.ready) begin
                o_byte.valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (buf_load) begin
            o_byte.data      <= shift_q;
            o_byte.frame_err <= !rx_s;  // Low stop bit
        end
    end

    a_valid_hold: assert property (
        @(posedge i_clk) disable iff (i_reset)
        (o_byte.valid && !o_byte.ready) |=> o_byte.valid
    );

    a_data_hold: assert property (
        @(posedge i_clk) disable iff (i_reset)
        (o_byte.valid && !o_byte.ready) |=> ($stable(o_byte.data) && $stable(o_byte.frame_err))
    );

endmodule

// File: rtl/uart_rx_hub.sv
`timescale 1ns/1ps

module uart_rx_hub (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_psel,
    input  logic                        i_penable,
    input  logic                        i_pwrite,
    input  logic [uart_pkg::APB_AW-1:0] i_paddr,
    input  logic [uart_pkg::APB_DW-1:0] i_pwdata,
    input  logic [uart_pkg::NUM_CH-1:0] i_rx,
    output logic [uart_pkg::APB_DW-1:0] o_prdata
);
    import uart_pkg::*;

    logic [DIV_W-1:0] divisor;
    logic             tick;         // Shared 16x tick

    rx_byte_if rx_bytes [NUM_CH] ();

    baud_tick_gen u_tick_gen (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_divisor (divisor),
        .o_tick    (tick)
    );

    for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_ch
        uart_rx_channel u_rx_channel (
            .i_clk   (i_clk),
            .i_reset (i_reset),
            .i_tick  (tick),
            .i_rx    (i_rx[ch]),
            .o_byte  (rx_bytes[ch])
        );
    end

    rx_apb_regs u_regs (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_prdata  (o_prdata),
        .o_divisor (divisor),
        .i_bytes   (rx_bytes)
    );

endmodule

// File: sim/rx_checker.sv
`timescale 1ns/1ps

module rx_checker (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_psel,
    input  logic                        i_penable,
    input  logic                        i_pwrite,
    input  logic [uart_pkg::APB_AW-1:0] i_paddr,
    input  logic [uart_pkg::APB_DW-1:0] i_pwdata,
    input  logic [uart_pkg::NUM_CH-1:0] i_rx,
    input  logic [uart_pkg::APB_DW-1:0] i_prdata,
    output int                          o_errors,
    output int                          o_checks
);
    import uart_pkg::*;

    logic [DIV_W-1:0]     div_m;
    logic [NUM_CH-1:0]    ovr_m;
    logic [NUM_CH-1:0]    ferr_m;
    int                   occ      [NUM_CH];      // Data register plus channel buffer
    logic [DATA_BITS-1:0] q_data   [NUM_CH][2];   // Entry 0 is the data register
    logic                 q_ferr   [NUM_CH][2];
    logic                 in_frame [NUM_CH];
    logic                 prev_rx  [NUM_CH];
    int                   cnt      [NUM_CH];      // Clocks since the start edge
    logic [DATA_BITS-1:0] shift    [NUM_CH];

    function automatic logic [APB_AW-1:0] data_addr(input int ch);
        return 8'h10 + 8'(4 * ch);
    endfunction

    // Expected read data from the model state
    function automatic logic [APB_DW-1:0] expected_rdata(input logic [APB_AW-1:0] addr);
        logic [APB_DW-1:0] value;
        value = '0;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            if (addr == REG_STATUS) begin
                value[ch]     = (occ[ch] != 0);
                value[4 + ch] = ovr_m[ch];
                value[8 + ch] = ferr_m[ch];
            end else if (addr == data_addr(ch) && occ[ch] != 0) begin
                value = 32'(q_data[ch][0]);
            end
        end
        if (addr == REG_DIVISOR) begin
            value = 32'(div_m);
        end
        return value;
    endfunction

    task automatic store_byte(input int ch, input logic [DATA_BITS-1:0] data, input logic ferr);
        if (occ[ch] == 2) begin
            ovr_m[ch] = 1'b1;                           // Both slots taken, byte lost
        end else begin
            q_data[ch][occ[ch]] = data;
            q_ferr[ch][occ[ch]] = ferr;
            if (occ[ch] == 0) begin
                ferr_m[ch] = ferr_m[ch] | ferr;
            end
            occ[ch] = occ[ch] + 1;
        end
    endtask

    task automatic pop_byte(input int ch);
        if (occ[ch] > 0) begin
            q_data[ch][0] = q_data[ch][1];
            q_ferr[ch][0] = q_ferr[ch][1];
            occ[ch] = occ[ch] - 1;
            if (occ[ch] > 0) begin
                ferr_m[ch] = ferr_m[ch] | q_ferr[ch][0];  // Flag follows the byte in
            end
        end
    endtask

    // Bit-level receiver sampling each bit at its middle
    task automatic decode_line(input int ch);
        int bit_clks;
        int half;
        int k;
        bit_clks = (int'(div_m) + 1) * OVERSAMPLE;
        half     = bit_clks / 2;
        if (!in_frame[ch]) begin
            if (prev_rx[ch] && !i_rx[ch]) begin
                in_frame[ch] = 1'b1;
                cnt[ch]      = 0;
            end
        end else begin
            cnt[ch] = cnt[ch] + 1;
            if (cnt[ch] == half) begin
                in_frame[ch] = !i_rx[ch];               // High again is a glitch
            end else if (cnt[ch] > half && (cnt[ch] - half) % bit_clks == 0) begin
                k = (cnt[ch] - half) / bit_clks;
                if (k <= DATA_BITS) begin
                    shift[ch][k-1] = i_rx[ch];
                end else begin
                    store_byte(ch, shift[ch], !i_rx[ch]);
                    in_frame[ch] = 1'b0;
                end
            end
        end
        prev_rx[ch] = i_rx[ch];
    endtask

    task automatic check_apb();
        logic [APB_DW-1:0] expected;
        if (i_psel && i_penable) begin
            if (i_pwrite && i_paddr == REG_DIVISOR) begin
                div_m = i_pwdata[DIV_W-1:0];
            end else if (i_pwrite && i_paddr == REG_CLEAR) begin
                ovr_m  = ovr_m & ~i_pwdata[7:4];
                ferr_m = ferr_m & ~i_pwdata[11:8];
            end else if (!i_pwrite) begin
                expected = expected_rdata(i_paddr);
                o_checks = o_checks + 1;
                if (i_prdata !== expected) begin
                    o_errors = o_errors + 1;
                    $display("[FAIL] %0d ns: o_prdata at 0x%02h is 0x%08h, expected 0x%08h",
                             $time, i_paddr, i_prdata, expected);
                end
                for (int ch = 0; ch < NUM_CH; ch++) begin
                    if (i_paddr == data_addr(ch)) begin
                        pop_byte(ch);
                    end
                end
            end
        end
    endtask

    // Falling edge, inputs are settled mid-cycle
    always @(negedge i_clk) begin
        if (i_reset) begin
            div_m    = DIV_RESET;
            ovr_m    = '0;
            ferr_m   = '0;
            o_errors = 0;
            o_checks = 0;
            for (int ch = 0; ch < NUM_CH; ch++) begin
                occ[ch]      = 0;
                in_frame[ch] = 1'b0;
                prev_rx[ch]  = 1'b1;
                cnt[ch]      = 0;
            end
        end else begin
            check_apb();
            for (int ch = 0; ch < NUM_CH; ch++) begin
                decode_line(ch);
            end
        end
    end

endmodule

// File: sim/tb_uart_rx_hub.sv
`timescale 1ns/1ps

module tb_uart_rx_hub;
    import uart_pkg::*;

    localparam int CLK_NS      = 40;
    localparam int RESET_CYC   = 10;
    localparam int TEST_DIV    = 1;
    localparam int BIT_CLKS    = (TEST_DIV + 1) * OVERSAMPLE;  // 32 clocks per bit
    localparam int FRAME_NS    = 10 * BIT_CLKS * CLK_NS;
    localparam int FRAME_SLOTS = 5;                            // Parallel frames count once
    localparam int TIMEOUT_NS  = 2 * FRAME_SLOTS * FRAME_NS + RESET_CYC * CLK_NS;

    logic               clk;
    logic               reset;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [APB_AW-1:0]  paddr;
    logic [APB_DW-1:0]  pwdata;
    logic [NUM_CH-1:0]  rx;
    logic [APB_DW-1:0]  prdata;
    int                 errors;
    int                 checks;
    logic [31:0]        lcg_state;
    logic [7:0]         bytes [NUM_CH];

    uart_rx_hub i_uart_rx_hub (
        .i_clk     (clk),
        .i_reset   (reset),
        .i_psel    (psel),
        .i_penable (penable),
        .i_pwrite  (pwrite),
        .i_paddr   (paddr),
        .i_pwdata  (pwdata),
        .i_rx      (rx),
        .o_prdata  (prdata)
    );

    rx_checker i_rx_checker (
        .i_clk     (clk),
        .i_reset   (reset),
        .i_psel    (psel),
        .i_penable (penable),
        .i_pwrite  (pwrite),
        .i_paddr   (paddr),
        .i_pwdata  (pwdata),
        .i_rx      (rx),
        .i_prdata  (prdata),
        .o_errors  (errors),
        .o_checks  (checks)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_byte(output logic [7:0] value);
        lcg_state = lcg_next(lcg_state);
        value     = lcg_state[23:16];
    endtask

    task automatic idle_clocks(input int n);
        repeat (n) @(posedge clk);
    endtask

    // Setup phase, access phase, then idle
    task automatic apb_transfer(input logic write, input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        #2;
        psel   = 1'b1;
        pwrite = write;
        paddr  = addr;
        pwdata = data;
        @(posedge clk);
        #2;
        penable = 1'b1;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // Start bit, eight data bits LSB first, stop bit
    task automatic send_frame(input int ch, input logic [7:0] data, input logic stop_bit);
        logic [9:0] bits;
        bits = {stop_bit, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #2;
            rx[ch] = bits[i];
            idle_clocks(BIT_CLKS - 1);
        end
        @(posedge clk);
        #2;
        rx[ch] = 1'b1;
    endtask

    task automatic send_glitch(input int ch, input int low_clks);
        @(posedge clk);
        #2;
        rx[ch] = 1'b0;
        idle_clocks(low_clks);
        #2;
        rx[ch] = 1'b1;
    endtask

    initial begin
        reset     = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        rx        = '1;                                   // Idle lines high
        lcg_state = 32'd3;
        idle_clocks(RESET_CYC);
        #2;
        reset = 1'b0;

        apb_transfer(1'b0, REG_STATUS, '0);
        apb_transfer(1'b0, REG_DIVISOR, '0);
        apb_transfer(1'b1, REG_DIVISOR, TEST_DIV);
        apb_transfer(1'b0, REG_DIVISOR, '0);
        idle_clocks(64);                                  // Old tick period runs out

        for (int ch = 0; ch < NUM_CH; ch++) begin
            next_byte(bytes[ch]);
        end
        fork
            send_frame(0, bytes[0], 1'b1);
            send_frame(1, bytes[1], 1'b1);
            send_frame(2, bytes[2], 1'b1);
            send_frame(3, bytes[3], 1'b1);
        join
        idle_clocks(2 * BIT_CLKS);
        apb_transfer(1'b0, REG_STATUS, '0);
        for (int ch = 0; ch < NUM_CH; ch++) begin
            apb_transfer(1'b0, DATA_ADDR[ch], '0);
        end
        apb_transfer(1'b0, REG_STATUS, '0);

        next_byte(bytes[1]);
        send_frame(1, bytes[1], 1'b0);                    // Low stop bit
        idle_clocks(2 * BIT_CLKS);
        apb_transfer(1'b0, REG_STATUS, '0);
        apb_transfer(1'b0, REG_DATA1, '0);
        apb_transfer(1'b1, REG_CLEAR, 32'h0000_0F00);
        apb_transfer(1'b0, REG_STATUS, '0);

        for (int i = 0; i < 3; i++) begin
            next_byte(bytes[2]);
            send_frame(2, bytes[2], 1'b1);
        end
        idle_clocks(2 * BIT_CLKS);
        apb_transfer(1'b0, REG_STATUS, '0);
        apb_transfer(1'b0, REG_DATA2, '0);
        apb_transfer(1'b0, REG_DATA2, '0);
        apb_transfer(1'b1, REG_CLEAR, 32'h0000_00F0);
        apb_transfer(1'b0, REG_STATUS, '0);

        send_glitch(3, BIT_CLKS / 4);
        idle_clocks(2 * BIT_CLKS);
        apb_transfer(1'b0, REG_STATUS, '0);
        apb_transfer(1'b0, REG_DATA3, '0);
        idle_clocks(4);

        $display("Reads checked: %0d, errors: %0d", checks, errors);
        if (checks == 0) begin
            $display("No APB read reached the checker");
        end
        if (errors == 0 && checks > 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired at %0d ns before the test sequence ended", $time);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule
